/* arrayAllocator.sv */
//----------------------------------------------------------------------
// Array allocator
// Hands out freed arrays first, newest first, then fresh numbers
//----------------------------------------------------------------------
`timescale 1ns/1ps

module arrayAllocator (
  input  logic             clock,
  input  logic             resetN,
  input  heapPkg::arrayIdT array,
  input  logic             clearAll,
  input  logic             takeArray,
  input  logic             returnArray,
  output logic             selIssued,
  output logic             canAlloc,
  output heapPkg::arrayIdT allocId
);
  import heapPkg::*;

  logic [arrayBits:0] freshCount;                 // Arrays ever issued, 0..4
  logic [arrayBits:0] stackTop;                   // Entries on free stack
  logic [arrayBits:0] topBelow;
  arrayIdT            freeStack [arrayCount];
  logic               stackEmpty;

  assign stackEmpty = stackTop == '0;
  assign topBelow   = stackTop - 1'b1;

  //--------------------------------------------------------------------
  // Counter and stack updates
  //--------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      freshCount <= '0;
      stackTop   <= '0;
    end else if (clearAll) begin
      freshCount <= '0;
      stackTop   <= '0;
    end else if (takeArray) begin
      if (!stackEmpty) stackTop <= topBelow;      // Reuse before fresh
      else freshCount <= freshCount + 1'b1;
    end else if (returnArray) begin
      stackTop <= stackTop + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (returnArray && !clearAll) freeStack[stackTop[arrayBits-1:0]] <= array;
  end

  assign allocId   = stackEmpty ? freshCount[arrayBits-1:0]
                                : freeStack[topBelow[arrayBits-1:0]];
  assign canAlloc  = !stackEmpty || (freshCount < (arrayBits + 1)'(arrayCount));
  assign selIssued = {1'b0, array} < freshCount;

  // Only allocated arrays are freed, so the stack cannot overflow
  assert property (@(posedge clock) disable iff (!resetN)
    returnArray |-> stackTop < (arrayBits + 1)'(arrayCount));

endmodule

/* elementAlu.sv */
//----------------------------------------------------------------------
// Element arithmetic
// Index search over the selected array and element add
//----------------------------------------------------------------------
`timescale 1ns/1ps

module elementAlu (
  input  heapPkg::rowT  selRow,
  input  heapPkg::sizeT selSize,
  input  heapPkg::dataT selElement,
  input  heapPkg::dataT data,
  output heapPkg::dataT indexResult,
  output heapPkg::dataT addResult
);
  import heapPkg::*;

  sizeT match;                                    // Highest hit plus one

  //--------------------------------------------------------------------
  // Search
  //--------------------------------------------------------------------
  always_comb begin
    match = '0;
    for (int i = 0; i < arrayLength; i++) begin
      // Later positions overwrite earlier hits
      if (sizeT'(i) < selSize && selRow[i] == data) begin
        match = sizeT'(i + 1);
      end
    end
  end

  assign indexResult = dataT'(match);

  //--------------------------------------------------------------------
  // Add
  //--------------------------------------------------------------------
  assign addResult = selElement + data;           // Wraps at 4096

endmodule

/* elementStore.sv */
//----------------------------------------------------------------------
// Element store
// Holds every element of every array and shows the selected array
//----------------------------------------------------------------------
`timescale 1ns/1ps

module elementStore (
  input  logic             clock,
  input  logic             resetN,
  input  heapPkg::arrayIdT array,
  input  heapPkg::indexT   index,
  input  logic             writeEn,
  input  heapPkg::indexT   writeIndex,
  input  heapPkg::dataT    writeData,
  output heapPkg::rowT     selRow,
  output heapPkg::dataT    selElement
);
  import heapPkg::*;

  rowT store [arrayCount];                        // One row per array

  //--------------------------------------------------------------------
  // Element write
  //--------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < arrayCount; a++) begin
        store[a] <= '0;
      end
    end else if (writeEn) begin
      store[array][writeIndex] <= writeData;      // Always the selected array
    end
  end

  //--------------------------------------------------------------------
  // Selected array view
  //--------------------------------------------------------------------
  assign selRow     = store[array];
  assign selElement = selRow[index];

endmodule

/* heapControl.sv */
//----------------------------------------------------------------------
// Heap command control
// Checks each command against the array status, raises the update
// strobes for legal commands and registers the one-cycle response
//----------------------------------------------------------------------
`timescale 1ns/1ps

module heapControl (
  input  logic              clock,
  input  logic              resetN,
  input  logic              start,
  input  heapPkg::heapCmdT  cmd,
  input  heapPkg::sizeT     selSize,
  input  logic              selAllocated,
  input  logic              selIssued,
  input  logic              canAlloc,
  input  heapPkg::arrayIdT  allocId,
  input  heapPkg::dataT     selElement,
  input  heapPkg::rowT      selRow,
  input  heapPkg::dataT     indexResult,
  input  heapPkg::dataT     addResult,
  output logic              done,
  output heapPkg::heapRespT resp,
  output logic              clearAll,
  output logic              markAlloc,
  output logic              markFree,
  output logic              setSize,
  output heapPkg::sizeT     newSize,
  output logic              writeEn,
  output heapPkg::indexT    writeIndex,
  output heapPkg::dataT     writeData,
  output logic              takeArray,
  output logic              returnArray
);
  import heapPkg::*;

  dataT  nextResult;
  errorT nextError;
  sizeT  indexPlusOne;                            // Size implied by a write
  sizeT  sizeMinusOne;                            // Size after a pop
  logic  outOfBounds;

  assign indexPlusOne = sizeT'({1'b0, cmd.index}) + sizeT'(1);
  assign sizeMinusOne = selSize - sizeT'(1);
  assign outOfBounds  = sizeT'({1'b0, cmd.index}) >= selSize;

  //--------------------------------------------------------------------
  // Decode and legality
  //--------------------------------------------------------------------
  always_comb begin
    nextResult  = '0;
    nextError   = errNone;
    clearAll    = 1'b0;
    markAlloc   = 1'b0;
    markFree    = 1'b0;
    setSize     = 1'b0;
    newSize     = '0;
    writeEn     = 1'b0;
    writeIndex  = cmd.index;
    writeData   = cmd.data;
    takeArray   = 1'b0;
    returnArray = 1'b0;
    if (start) begin
      if (cmd.op == opClear) begin
        clearAll = 1'b1;
      end else if (cmd.op == opAlloc) begin
        if (canAlloc) begin
          markAlloc  = 1'b1;
          takeArray  = 1'b1;
          nextResult = dataT'(allocId);
        end else begin
          nextError = errOutOfMemory;
        end
      end else if (!selIssued) begin
        nextError = errNotAllocated;
      end else if (!selAllocated) begin
        nextError = errFreed;
      end else begin
        unique case (cmd.op)
          opFree: begin
            markFree    = 1'b1;
            returnArray = 1'b1;
          end
          opWrite: begin
            writeEn    = 1'b1;
            setSize    = indexPlusOne > selSize;  // Grow only
            newSize    = indexPlusOne;
            nextResult = cmd.data;
          end
          opRead: begin
            if (outOfBounds) nextError = errOutOfBounds;
            else nextResult = selElement;
          end
          opSize: nextResult = dataT'(selSize);
          opPush: begin
            if (selSize < sizeT'(arrayLength)) begin
              writeEn    = 1'b1;
              writeIndex = indexT'(selSize);      // Next free slot
              setSize    = 1'b1;
              newSize    = selSize + sizeT'(1);
              nextResult = dataT'(selSize + sizeT'(1));
            end else begin
              nextError = errFull;
            end
          end
          opPop: begin
            if (selSize != '0) begin
              setSize    = 1'b1;
              newSize    = sizeMinusOne;
              nextResult = selRow[indexT'(sizeMinusOne)];
            end else begin
              nextError = errEmpty;
            end
          end
          opIndex: nextResult = indexResult;
          opAdd: begin
            if (outOfBounds) begin
              nextError = errOutOfBounds;
            end else begin
              writeEn    = 1'b1;
              writeData  = addResult;
              nextResult = addResult;
            end
          end
          default: ;                              // Clear and Alloc above
        endcase
      end
    end
  end

  //--------------------------------------------------------------------
  // Response register
  //--------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done <= 1'b0;
      resp <= '0;
    end else begin
      done <= start;
      if (start) resp <= '{result: nextResult, error: nextError};
    end
  end

  // A response always belongs to the command of the cycle before
  assert property (@(posedge clock) disable iff (!resetN) done |-> $past(start));

  assert property (@(posedge clock) disable iff (!resetN)
    $onehot0({clearAll, markAlloc, markFree, setSize}));

endmodule

/* heapMemory.f */
heapPkg.sv
elementStore.sv
sizeTable.sv
arrayAllocator.sv
elementAlu.sv
heapControl.sv
heapMemory.sv
tbClock.sv
heapMemoryTb.sv

/* heapMemory.sv */
//----------------------------------------------------------------------
// Array heap memory
// Four arrays of up to eight elements with one-cycle commands
//----------------------------------------------------------------------
`timescale 1ns/1ps

module heapMemory (
  input  logic              clock,
  input  logic              resetN,
  input  logic              start,
  input  heapPkg::heapCmdT  cmd,
  output logic              done,
  output heapPkg::heapRespT resp
);
  import heapPkg::*;

  sizeT    selSize, newSize;
  logic    selAllocated, selIssued, canAlloc;
  arrayIdT allocId;
  dataT    selElement, indexResult, addResult, writeData;
  rowT     selRow;
  logic    clearAll, markAlloc, markFree, setSize;
  logic    writeEn, takeArray, returnArray;
  indexT   writeIndex;

  heapControl control (
    .clock, .resetN, .start, .cmd,
    .selSize, .selAllocated, .selIssued, .canAlloc, .allocId,
    .selElement, .selRow, .indexResult, .addResult,
    .done, .resp,
    .clearAll, .markAlloc, .markFree, .setSize, .newSize,
    .writeEn, .writeIndex, .writeData,
    .takeArray, .returnArray
  );

  elementStore store (
    .clock, .resetN,
    .array (cmd.array),
    .index (cmd.index),
    .writeEn, .writeIndex, .writeData,
    .selRow, .selElement
  );

  sizeTable sizes (
    .clock, .resetN,
    .array (cmd.array),
    .allocId, .clearAll, .markAlloc, .markFree, .setSize, .newSize,
    .selSize, .selAllocated
  );

  arrayAllocator allocator (
    .clock, .resetN,
    .array (cmd.array),
    .clearAll, .takeArray, .returnArray,
    .selIssued, .canAlloc, .allocId
  );

  elementAlu alu (
    .selRow, .selSize, .selElement,
    .data (cmd.data),
    .indexResult, .addResult
  );

endmodule

/* heapMemoryTb.sv */
//----------------------------------------------------------------------
// Heap memory testbench
// Applies a table of commands and checks each response
//----------------------------------------------------------------------
`timescale 1ns/1ps

module heapMemoryTb;
  import heapPkg::*;

  localparam int doneTimeout  = 10;               // Cycles to wait for done
  localparam int resetTimeout = 10;

  typedef struct packed {
    heapCmdT cmd;
    dataT    result;
    errorT   error;
    logic    chained;                             // Next command on the very next cycle
  } stepT;

  logic     clock;
  logic     resetN;
  logic     start;
  heapCmdT  cmd;
  logic     done;
  heapRespT resp;

  stepT steps[$];
  int   doneCount = 0;

  tbClock clockGen (.clock, .resetN);

  heapMemory dut (.clock, .resetN, .start, .cmd, .done, .resp);

  // Every cycle with done high counts as one response
  always @(posedge clock) begin
    if (resetN && done) doneCount <= doneCount + 1;
  end

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      abortRun($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic addStep(input opcodeT op, input int array, input int index, input int data,
                         input int result, input errorT error, input logic chained);
    stepT s;
    s.cmd     = '{op: op, array: arrayIdT'(array), index: indexT'(index), data: dataT'(data)};
    s.result  = dataT'(result);
    s.error   = error;
    s.chained = chained;
    steps.push_back(s);
  endtask

  task automatic waitForDone(input int stepNo, output int cycles);
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
      if (cycles > doneTimeout) begin
        abortRun($sformatf("Timeout: no done within %0d cycles for step %0d",
                           doneTimeout, stepNo));
      end
    end while (done !== 1'b1);
  endtask

  //--------------------------------------------------------------------
  // Command table
  //--------------------------------------------------------------------
  task automatic buildTable();
    // Reset, Clear and fresh allocation
    addStep(opClear, 0, 0, 0, 0, errNone, 1'b0);
    addStep(opRead, 0, 0, 0, 0, errNotAllocated, 1'b0);
    for (int k = 0; k < 4; k++) addStep(opAlloc, 0, 0, 0, k, errNone, 1'b0);
    addStep(opAlloc, 0, 0, 0, 0, errOutOfMemory, 1'b0);
    // Free and reuse, newest freed first
    addStep(opFree, 1, 0, 0, 0, errNone, 1'b0);
    addStep(opFree, 2, 0, 0, 0, errNone, 1'b0);
    addStep(opWrite, 2, 3, 'h5a5, 0, errFreed, 1'b0);
    addStep(opAlloc, 0, 0, 0, 2, errNone, 1'b0);
    addStep(opAlloc, 0, 0, 0, 1, errNone, 1'b0);
    addStep(opWrite, 2, 4, 'h111, 'h111, errNone, 1'b0);
    addStep(opRead, 2, 3, 0, 0, errNone, 1'b0);   // Rejected write left nothing
    // Write, Read and Size
    addStep(opWrite, 0, 5, 'habc, 'habc, errNone, 1'b0);
    addStep(opSize, 0, 0, 0, 6, errNone, 1'b0);
    addStep(opRead, 0, 6, 0, 0, errOutOfBounds, 1'b0);
    addStep(opRead, 0, 5, 0, 'habc, errNone, 1'b0);
    // Push to full, pop to empty
    for (int k = 0; k < 8; k++) addStep(opPush, 3, 0, 'h101 + k, k + 1, errNone, 1'b0);
    addStep(opPush, 3, 0, 'h109, 0, errFull, 1'b0);
    for (int k = 0; k < 8; k++) addStep(opPop, 3, 0, 0, 'h108 - k, errNone, 1'b0);
    addStep(opPop, 3, 0, 0, 0, errEmpty, 1'b0);
    // Index search
    addStep(opWrite, 1, 0, 'h033, 'h033, errNone, 1'b0);
    addStep(opWrite, 1, 1, 'h044, 'h044, errNone, 1'b0);
    addStep(opWrite, 1, 2, 'h033, 'h033, errNone, 1'b0);
    addStep(opWrite, 1, 3, 'h055, 'h055, errNone, 1'b0);
    addStep(opIndex, 1, 0, 'h033, 3, errNone, 1'b0);
    addStep(opIndex, 1, 0, 'h044, 2, errNone, 1'b0);
    addStep(opIndex, 1, 0, 'h077, 0, errNone, 1'b0);
    addStep(opIndex, 3, 0, 'h105, 0, errNone, 1'b0);  // Old data past the size
    addStep(opPush, 3, 0, 'h0aa, 1, errNone, 1'b0);
    addStep(opIndex, 3, 0, 'h102, 0, errNone, 1'b0);
    addStep(opIndex, 3, 0, 'h0aa, 1, errNone, 1'b0);
    // Add with wrap
    addStep(opWrite, 1, 4, 'h002, 'h002, errNone, 1'b0);
    addStep(opAdd, 1, 4, 'hfff, 'h001, errNone, 1'b0);
    addStep(opRead, 1, 4, 0, 'h001, errNone, 1'b0);
    addStep(opAdd, 1, 5, 'h001, 0, errOutOfBounds, 1'b0);
    // Back-to-back commands
    addStep(opWrite, 0, 2, 'h321, 'h321, errNone, 1'b1);
    addStep(opRead, 0, 2, 0, 'h321, errNone, 1'b1);
    addStep(opAdd, 0, 2, 'h001, 'h322, errNone, 1'b1);
    addStep(opSize, 0, 0, 0, 6, errNone, 1'b1);
    addStep(opFree, 0, 0, 0, 0, errNone, 1'b1);
    addStep(opRead, 0, 2, 0, 0, errFreed, 1'b0);
    // Clear empties the free stack too
    addStep(opFree, 2, 0, 0, 0, errNone, 1'b0);   // Leaves 2 on top of the stack
    addStep(opClear, 0, 0, 0, 0, errNone, 1'b0);
    addStep(opRead, 3, 0, 0, 0, errNotAllocated, 1'b0);
    addStep(opAlloc, 0, 0, 0, 0, errNone, 1'b0);
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------
  initial begin
    int cycles;
    int latency;
    start = 1'b0;
    cmd   = '0;
    buildTable();

    cycles = 0;
    while (resetN !== 1'b1) begin
      @(posedge clock);
      cycles++;
      if (cycles > resetTimeout) abortRun("Reset was never released");
    end

    repeat (3) begin
      @(negedge clock);
      checkValue("done", 32'(done), 32'd0);       // Idle after reset
      checkValue("resp", 32'(resp), 32'd0);
    end

    for (int i = 0; i < steps.size(); i++) begin
      start = 1'b1;
      cmd   = steps[i].cmd;
      waitForDone(i, latency);
      checkValue($sformatf("done latency (step %0d)", i), latency, 1);
      checkValue($sformatf("resp.result (step %0d)", i), 32'(resp.result),
                 32'(steps[i].result));
      checkValue($sformatf("resp.error (step %0d)", i), 32'(resp.error),
                 32'(steps[i].error));
      if (!steps[i].chained) begin
        start = 1'b0;
        @(negedge clock);
        checkValue($sformatf("done after step %0d", i), 32'(done), 32'd0);
      end
    end

    repeat (2) @(negedge clock);
    checkValue("done count", doneCount, steps.size());
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* heapPkg.sv */
//----------------------------------------------------------------------
// Array heap package
// Sizes, value types, opcodes, error kinds and the command and
// response structs shared by the heap memory blocks
//----------------------------------------------------------------------
package heapPkg;

  //--------------------------------------------------------------------
  // Sizes
  //--------------------------------------------------------------------
  localparam int arrayBits   = 2;                 // Array number width
  localparam int indexBits   = 3;                 // Element index width
  localparam int dataBits    = 12;                // Element width
  localparam int arrayCount  = 4;                 // Number of arrays
  localparam int arrayLength = 8;                 // Elements per array

  //--------------------------------------------------------------------
  // Value types
  //--------------------------------------------------------------------
  typedef logic [arrayBits-1:0] arrayIdT;         // Array number
  typedef logic [indexBits:0]   sizeT;            // Size 0..arrayLength
  typedef logic [indexBits-1:0] indexT;           // Element index
  typedef logic [dataBits-1:0]  dataT;            // Element or result

  typedef dataT [arrayLength-1:0] rowT;           // One whole array

  //--------------------------------------------------------------------
  // Operations and errors
  //--------------------------------------------------------------------
  typedef enum logic [3:0] {
    opClear = 4'd0,                               // Forget every array
    opAlloc = 4'd1,
    opFree  = 4'd2,
    opWrite = 4'd3,
    opRead  = 4'd4,
    opSize  = 4'd5,
    opPush  = 4'd6,
    opPop   = 4'd7,
    opIndex = 4'd8,                               // Search for data
    opAdd   = 4'd9                                // Add data to element
  } opcodeT;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                       // Never handed out
    errFreed        = 3'd2,                       // Handed out then freed
    errOutOfBounds  = 3'd3,
    errFull         = 3'd4,
    errEmpty        = 3'd5,
    errOutOfMemory  = 3'd6
  } errorT;

  // Command and response as they cross the block boundary
  typedef struct packed {
    opcodeT  op;
    arrayIdT array;
    indexT   index;
    dataT    data;
  } heapCmdT;

  typedef struct packed {
    dataT  result;
    errorT error;
  } heapRespT;

endpackage

/* run.sh */
#!/bin/sh
# Builds the heap memory testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module heapMemoryTb -f heapMemory.f -o heapSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/heapSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
  echo "Test run passed"
  exit 0
fi

echo "Pass message not found in sim.log"
exit 1

/* sizeTable.sv */
//----------------------------------------------------------------------
// Array size table
// Current size and allocated flag of each array
//----------------------------------------------------------------------
`timescale 1ns/1ps

module sizeTable (
  input  logic             clock,
  input  logic             resetN,
  input  heapPkg::arrayIdT array,
  input  heapPkg::arrayIdT allocId,
  input  logic             clearAll,
  input  logic             markAlloc,
  input  logic             markFree,
  input  logic             setSize,
  input  heapPkg::sizeT    newSize,
  output heapPkg::sizeT    selSize,
  output logic             selAllocated
);
  import heapPkg::*;

  sizeT                  sizes [arrayCount];
  logic [arrayCount-1:0] allocated;               // One flag per array

  //--------------------------------------------------------------------
  // Updates
  //--------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      for (int a = 0; a < arrayCount; a++) begin
        sizes[a] <= '0;
      end
    end else if (clearAll) begin
      allocated <= '0;
      for (int a = 0; a < arrayCount; a++) begin
        sizes[a] <= '0;
      end
    end else if (markAlloc) begin
      sizes[allocId]     <= '0;                   // Fresh arrays start empty
      allocated[allocId] <= 1'b1;
    end else if (markFree) begin
      allocated[array] <= 1'b0;
    end else if (setSize) begin
      sizes[array] <= newSize;                    // Grow, push or pop
    end
  end

  assign selSize      = sizes[array];
  assign selAllocated = allocated[array];

  // Control must never grow an array past its storage
  for (genvar g = 0; g < arrayCount; g++) begin : gSizeCheck
    assert property (@(posedge clock) disable iff (!resetN)
      sizes[g] <= sizeT'(arrayLength));
  end

endmodule

/* tbClock.sv */
//----------------------------------------------------------------------
// Testbench clock and reset
// 20 ns clock, reset held low for the first two cycles
//----------------------------------------------------------------------
`timescale 1ns/1ps

module tbClock (
  output logic clock,
  output logic resetN
);
  localparam int halfPeriod  = 10;                // 20 ns period
  localparam int resetCycles = 2;

  initial begin
    clock = 1'b0;
    forever #halfPeriod clock = ~clock;
  end

  initial begin
    resetN = 1'b0;
    repeat (resetCycles) @(negedge clock);        // Release away from the rising edge
    resetN = 1'b1;
  end

endmodule
